//--- lb_params.svh
`ifndef LB_PARAMS_SVH
`define LB_PARAMS_SVH

`default_nettype none

// Pixel depth.
`define LB_PIX_W 8

// Image geometry.
`define LB_IMG_W 8
`define LB_IMG_H 6

// One bank per row of the 3x3 window.
`define LB_BANKS 3

`define LB_COL_W 3 // Holds 0 to IMG_W-1.
`define LB_ROW_W 3 // Holds 0 to IMG_H-1.

`default_nettype wire

`endif

//--- lb_pkg.sv
`include "lb_params.svh"
`default_nettype none

package lb_pkg;

	typedef logic [`LB_PIX_W-1:0] pixel_t;
	typedef logic [`LB_COL_W-1:0] col_t; // Also the row RAM address.
	typedef logic [`LB_ROW_W-1:0] row_t;
	typedef logic [11:0] sum_t; // Up to 9 x 255.

	// Rotating job of a row RAM.
	typedef enum logic [1:0] {
		ROLE_WRITE  = 2'd0,
		ROLE_PREV   = 2'd1,
		ROLE_OLDEST = 2'd2
	} bank_role_e;

	// One accepted pixel with its position, sent to every bank.
	typedef struct packed {
		logic push;
		pixel_t pix;
		col_t col;
		row_t row;
		logic row_done;
		logic frame_done;
		logic emit;
	} row_beat_s;

	typedef struct packed {
		pixel_t rd_pix;
		bank_role_e role; // Role at the time of the read.
	} bank_out_s;

	typedef struct packed {
		sum_t sum;
		row_t row;
		col_t col;
	} window_s;

endpackage

`default_nettype wire

//--- row_sequencer.sv
`timescale 1ns/1ps
`include "lb_params.svh"
`default_nettype none

module row_sequencer (
	input wire logic clk,
	input wire logic aclr,
	input wire logic in_valid,
	input wire lb_pkg::pixel_t in_pix,
	input wire logic accept,
	output logic in_ready,
	output lb_pkg::row_beat_s beat
);

	import lb_pkg::*;

	col_t col_q;
	row_t row_q;
	logic push;
	logic last_col;
	logic last_row;

	assign in_ready = accept;
	assign push = in_valid && accept;

	assign last_col = (col_q == col_t'(`LB_IMG_W - 1));
	assign last_row = (row_q == row_t'(`LB_IMG_H - 1));

	always_comb
	begin
		beat.push = push;
		beat.pix = in_pix;
		beat.col = col_q;
		beat.row = row_q;
		beat.row_done = last_col;
		beat.frame_done = last_col && last_row;
		// Window is complete once two rows and two columns are behind it.
		beat.emit = (row_q >= row_t'(2)) && (col_q >= col_t'(2));
	end

	// Raster position of the next pixel.
	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			col_q <= '0;
			row_q <= '0;
		end
		else if (push)
		begin
			if (last_col)
			begin
				col_q <= '0;
				if (last_row)
				begin
					row_q <= '0; // Frame wraps.
				end
				else
				begin
					row_q <= row_q + row_t'(1);
				end
			end
			else
			begin
				col_q <= col_q + col_t'(1);
			end
		end
	end

	a_row_in_range: assert property (
		@(posedge clk) disable iff (aclr)
		row_q < row_t'(`LB_IMG_H)
	) else $error("row counter out of range");

endmodule

`default_nettype wire

//--- line_bank.sv
`timescale 1ns/1ps
`include "lb_params.svh"
`default_nettype none

module line_bank #(
	parameter int BANK_ID = 0
) (
	input wire logic clk,
	input wire logic aclr,
	input wire lb_pkg::row_beat_s beat,
	output lb_pkg::bank_out_s bank_out
);

	import lb_pkg::*;

	// Staggered so that the three banks never share a role.
	localparam bank_role_e RESET_ROLE = (BANK_ID == 0) ? ROLE_WRITE :
		(BANK_ID == 1) ? ROLE_OLDEST : ROLE_PREV;

	pixel_t mem [`LB_IMG_W];
	pixel_t rd_q;
	bank_role_e role_q;
	bank_role_e role_next;
	bank_role_e rd_role_q;
	logic wr_en;
	logic rd_en;

	assign wr_en = beat.push && (role_q == ROLE_WRITE);
	assign rd_en = beat.push && (role_q != ROLE_WRITE);

	always_comb
	begin
		role_next = role_q;
		if (beat.push && beat.frame_done)
		begin
			role_next = RESET_ROLE;
		end
		else if (beat.push && beat.row_done)
		begin
			case (role_q)
				ROLE_WRITE:  role_next = ROLE_PREV;
				ROLE_PREV:   role_next = ROLE_OLDEST;
				ROLE_OLDEST: role_next = ROLE_WRITE;
				default:     role_next = RESET_ROLE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			role_q <= RESET_ROLE;
			rd_role_q <= RESET_ROLE;
		end
		else
		begin
			role_q <= role_next;
			if (beat.push)
			begin
				rd_role_q <= role_q; // Tags the data read this cycle.
			end
		end
	end

	// Row RAM.
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[beat.col] <= beat.pix;
		end
		if (rd_en)
		begin
			rd_q <= mem[beat.col];
		end
	end

	always_comb
	begin
		bank_out.rd_pix = rd_q;
		bank_out.role = rd_role_q;
	end

	a_no_wr_rd: assert property (
		@(posedge clk) disable iff (aclr)
		!(wr_en && rd_en)
	) else $error("bank %0d wrote and read in one cycle", BANK_ID);

endmodule

`default_nettype wire

//--- window_summer.sv
`timescale 1ns/1ps
`include "lb_params.svh"
`default_nettype none

module window_summer (
	input wire logic clk,
	input wire logic aclr,
	input wire lb_pkg::row_beat_s beat,
	input wire lb_pkg::bank_out_s banks [`LB_BANKS],
	input wire logic out_ready,
	output logic accept,
	output logic out_valid,
	output lb_pkg::window_s out_win
);

	import lb_pkg::*;

	logic [`LB_BANKS-1:0] wr_mask;
	logic [`LB_BANKS-1:0] prev_mask;
	logic [`LB_BANKS-1:0] old_mask;
	pixel_t prev_pix;
	pixel_t old_pix;

	// Beat whose bank reads are in flight.
	logic pend_valid;
	logic pend_emit;
	pixel_t pend_pix;
	row_t pend_row;
	col_t pend_col;

	// Index 2 is the oldest row, index 0 the current one.
	pixel_t [2:0] new_col;
	pixel_t [2:0] hist1;
	pixel_t [2:0] hist2;
	sum_t win_sum;

	assign accept = !out_valid || out_ready;

	always_comb
	begin
		prev_pix = '0;
		old_pix = '0;
		for (int i = 0; i < `LB_BANKS; i++)
		begin
			wr_mask[i] = (banks[i].role == ROLE_WRITE);
			prev_mask[i] = (banks[i].role == ROLE_PREV);
			old_mask[i] = (banks[i].role == ROLE_OLDEST);
			if (prev_mask[i])
			begin
				prev_pix = banks[i].rd_pix;
			end
			if (old_mask[i])
			begin
				old_pix = banks[i].rd_pix;
			end
		end
	end

	assign new_col = {old_pix, prev_pix, pend_pix};

	always_comb
	begin
		win_sum = '0;
		for (int i = 0; i < 3; i++)
		begin
			win_sum = win_sum + sum_t'(new_col[i]) + sum_t'(hist1[i]) + sum_t'(hist2[i]);
		end
	end

	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			pend_valid <= 1'b0;
			out_valid <= 1'b0;
		end
		else if (accept)
		begin
			pend_valid <= beat.push;
			out_valid <= pend_valid && pend_emit;
		end
	end

	// Everything below holds while the output is stalled.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			if (beat.push)
			begin
				pend_pix <= beat.pix;
				pend_row <= beat.row;
				pend_col <= beat.col;
				pend_emit <= beat.emit;
			end
			if (pend_valid)
			begin
				hist2 <= hist1;
				hist1 <= new_col;
				if (pend_emit)
				begin
					out_win.sum <= win_sum;
					out_win.row <= pend_row;
					out_win.col <= pend_col;
				end
			end
		end
	end

	a_stall_stable: assert property (
		@(posedge clk) disable iff (aclr)
		out_valid && !out_ready |=> out_valid && $stable(out_win)
	) else $error("output changed while stalled");

	// Banks rotate in lock step, so each role is held exactly once.
	a_roles_unique: assert property (
		@(posedge clk) disable iff (aclr)
		$onehot(wr_mask) && $onehot(prev_mask) && $onehot(old_mask)
	) else $error("bank roles are not unique");

endmodule

`default_nettype wire

//--- line_filter_top.sv
`timescale 1ns/1ps
`include "lb_params.svh"
`default_nettype none

module line_filter_top (
	input wire logic clk,
	input wire logic aclr,
	input wire logic in_valid,
	input wire lb_pkg::pixel_t in_pix,
	output logic in_ready,
	output logic out_valid,
	output lb_pkg::window_s out_win,
	input wire logic out_ready
);

	import lb_pkg::*;

	row_beat_s beat;
	bank_out_s bank_outs [`LB_BANKS];
	logic accept;

	row_sequencer u_seq (
		.clk      (clk),
		.aclr     (aclr),
		.in_valid (in_valid),
		.in_pix   (in_pix),
		.accept   (accept),
		.in_ready (in_ready),
		.beat     (beat)
	);

	// One row RAM per window row, roles staggered by index.
	for (genvar i = 0; i < `LB_BANKS; i++)
	begin : g_bank
		line_bank #(
			.BANK_ID (i)
		) u_bank (
			.clk      (clk),
			.aclr     (aclr),
			.beat     (beat),
			.bank_out (bank_outs[i])
		);
	end

	window_summer u_sum (
		.clk       (clk),
		.aclr      (aclr),
		.beat      (beat),
		.banks     (bank_outs),
		.out_ready (out_ready),
		.accept    (accept),
		.out_valid (out_valid),
		.out_win   (out_win)
	);

endmodule

`default_nettype wire

//--- tb_line_filter.sv
`timescale 1ns/1ps
`include "lb_params.svh"
`default_nettype none

module tb_line_filter;

	import lb_pkg::*;

	localparam int FRAME_PIX = `LB_IMG_W * `LB_IMG_H;
	localparam int WINDOWS = (`LB_IMG_W - 2) * (`LB_IMG_H - 2);
	localparam int WAIT_LIMIT = 200;
	localparam int DRAIN_CYCLES = 20;

	logic clk;
	logic aclr;
	logic in_valid;
	pixel_t in_pix;
	logic in_ready;
	logic out_valid;
	window_s out_win;
	logic out_ready;

	int seed;
	int errors;
	int timeouts;

	pixel_t pix_q[$]; // Every frame of the current run, raster order.
	int gap_q[$]; // Idle cycles before each pixel.
	window_s exp_q[$];
	window_s got_q[$];
	window_s ref_q[$];

	line_filter_top DUT (
		.clk       (clk),
		.aclr      (aclr),
		.in_valid  (in_valid),
		.in_pix    (in_pix),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_win   (out_win),
		.out_ready (out_ready)
	);

	always #10 clk = ~clk;

	task automatic check_sum(input sum_t got, input sum_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s: sum %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_pos(input row_t got_row, input col_t got_col, input row_t exp_row,
		input col_t exp_col, input string what);
		if (got_row !== exp_row || got_col !== exp_col)
		begin
			$display("[FAIL] %0t ns: %s: at (%0d,%0d), expected (%0d,%0d)", $time, what,
				got_row, got_col, exp_row, exp_col);
			errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic add_ramp_frame();
		for (int r = 0; r < `LB_IMG_H; r++)
		begin
			for (int c = 0; c < `LB_IMG_W; c++)
			begin
				pix_q.push_back(pixel_t'(r * 8 + c));
			end
		end
	endtask

	task automatic add_random_frame();
		int rnd;
		for (int i = 0; i < FRAME_PIX; i++)
		begin
			rnd = $random(seed);
			pix_q.push_back(pixel_t'(rnd));
		end
	endtask

	// Sum of the 3x3 window ending at each pixel with row and column of at least two.
	task automatic build_model();
		int base;
		sum_t acc;
		window_s w;
		exp_q.delete();
		for (int f = 0; f < pix_q.size() / FRAME_PIX; f++)
		begin
			base = f * FRAME_PIX;
			for (int r = 2; r < `LB_IMG_H; r++)
			begin
				for (int c = 2; c < `LB_IMG_W; c++)
				begin
					acc = '0;
					for (int dr = 0; dr < 3; dr++)
					begin
						for (int dc = 0; dc < 3; dc++)
						begin
							acc = acc + sum_t'(pix_q[base + (r - dr) * `LB_IMG_W + c - dc]);
						end
					end
					w.sum = acc;
					w.row = row_t'(r);
					w.col = col_t'(c);
					exp_q.push_back(w);
				end
			end
		end
	endtask

	task automatic plan_gaps(input bit with_gaps);
		int rnd;
		gap_q.delete();
		for (int i = 0; i < pix_q.size(); i++)
		begin
			rnd = $random(seed);
			if (with_gaps && rnd[1:0] == 2'd0)
			begin
				gap_q.push_back(1 + int'(rnd[2]));
			end
			else
			begin
				gap_q.push_back(0);
			end
		end
	endtask

	task automatic send_pixels();
		int waits;
		logic taken;
		for (int i = 0; i < pix_q.size(); i++)
		begin
			in_valid = 1'b0;
			repeat (gap_q[i])
			begin
				@(posedge clk);
				#2;
			end
			in_valid = 1'b1;
			in_pix = pix_q[i];
			taken = 1'b0;
			waits = 0;
			while (!taken && waits < WAIT_LIMIT)
			begin
				@(negedge clk);
				taken = in_ready; // Transfer on the coming edge.
				@(posedge clk);
				#2;
				waits++;
			end
			if (!taken)
			begin
				$display("Timeout: pixel %0d was never accepted", i);
				timeouts++;
				break;
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic collect_results(input bit random_ready);
		int idle;
		int rnd;
		logic stalled;
		window_s held;
		got_q.delete();
		idle = 0;
		stalled = 1'b0;
		held = '0;
		while (got_q.size() < exp_q.size() && idle < WAIT_LIMIT)
		begin
			@(posedge clk);
			#2;
			rnd = $random(seed);
			out_ready = random_ready ? rnd[0] : 1'b1;
			@(negedge clk);
			if (stalled)
			begin
				check_bit(out_valid, 1'b1, "out_valid dropped while stalled");
				check_sum(out_win.sum, held.sum, "sum changed while stalled");
				check_pos(out_win.row, out_win.col, held.row, held.col,
					"position changed while stalled");
			end
			stalled = out_valid && !out_ready;
			held = out_win;
			if (out_valid && out_ready)
			begin
				got_q.push_back(out_win);
				idle = 0;
			end
			else
			begin
				idle++;
			end
		end
		if (got_q.size() < exp_q.size())
		begin
			$display("Timeout: only %0d of %0d results arrived", got_q.size(), exp_q.size());
			timeouts++;
		end
		// Pipeline must now be empty.
		for (int i = 0; i < DRAIN_CYCLES; i++)
		begin
			@(posedge clk);
			#2;
			out_ready = 1'b1;
			@(negedge clk);
			if (out_valid)
			begin
				$display("Unexpected extra result at row %0d col %0d", out_win.row, out_win.col);
				errors++;
			end
		end
	endtask

	task automatic compare_results(input string what);
		int n;
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++)
		begin
			check_sum(got_q[i].sum, exp_q[i].sum, what);
			check_pos(got_q[i].row, got_q[i].col, exp_q[i].row, exp_q[i].col, what);
		end
	endtask

	task automatic run_frames(input bit with_gaps, input bit random_ready, input string what);
		plan_gaps(with_gaps);
		build_model();
		@(posedge clk);
		#2;
		fork
			send_pixels();
			collect_results(random_ready);
		join
		compare_results(what);
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		check_bit(out_valid, 1'b0, "out_valid after reset");
		check_bit(in_ready, 1'b1, "in_ready after reset");
	endtask

	task automatic test_ramp_frame();
		pix_q.delete();
		add_ramp_frame();
		run_frames(1'b0, 1'b0, "ramp frame");
	endtask

	task automatic test_random_frame();
		pix_q.delete();
		add_random_frame();
		run_frames(1'b0, 1'b0, "random frame");
		if (got_q.size() != WINDOWS)
		begin
			$display("Random frame gave %0d results instead of %0d", got_q.size(), WINDOWS);
			errors++;
		end
		ref_q = got_q;
	endtask

	// Same pixels as the random frame, so results must equal the gap-free run.
	task automatic test_input_gaps();
		int n;
		run_frames(1'b1, 1'b0, "frame with input gaps");
		n = (got_q.size() < ref_q.size()) ? got_q.size() : ref_q.size();
		for (int i = 0; i < n; i++)
		begin
			check_sum(got_q[i].sum, ref_q[i].sum, "gapped against gap-free");
			check_pos(got_q[i].row, got_q[i].col, ref_q[i].row, ref_q[i].col,
				"gapped against gap-free");
		end
	endtask

	task automatic test_ready_toggle();
		pix_q.delete();
		add_random_frame();
		run_frames(1'b1, 1'b1, "frame with output stalls");
	endtask

	task automatic test_back_to_back();
		pix_q.delete();
		add_random_frame();
		add_ramp_frame();
		run_frames(1'b0, 1'b0, "back-to-back frames");
	endtask

	initial
	begin
		clk = 1'b0;
		aclr = 1'b1;
		in_valid = 1'b0;
		in_pix = '0;
		out_ready = 1'b1;
		seed = 32'h9a533426;
		errors = 0;
		timeouts = 0;
		repeat (16) @(posedge clk);
		#2;
		aclr = 1'b0;
		test_reset_state();
		test_ramp_frame();
		test_random_frame();
		test_input_gaps();
		test_ready_toggle();
		test_back_to_back();
		$display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
lb_pkg.sv
row_sequencer.sv
line_bank.sv
window_summer.sv
line_filter_top.sv
tb_line_filter.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the line filter testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f build.f \
	--top-module tb_line_filter \
	--Mdir obj_dir \
	-o tb_line_filter

status=0
./obj_dir/tb_line_filter > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TESTS FAILED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
